// File: design/aluUnit.sv
`timescale 1ns/1ps

module aluUnit import srcPkg::*; (
    input  aluOpT aluOp,
    input  logic [dataWidth-1:0] yValue,
    input  logic [dataWidth-1:0] busValue,
    output logic [2*dataWidth-1:0] result
);

    logic signed [2*dataWidth-1:0] product;
    logic [dataWidth-1:0] lowWord;

    assign product = $signed(yValue) * $signed(busValue);   // full signed product.

    always_comb begin
        case (aluOp)
            aluAdd:   lowWord = yValue + busValue;
            aluSub:   lowWord = yValue - busValue;
            aluAnd:   lowWord = yValue & busValue;
            aluOr:    lowWord = yValue | busValue;
            aluIncPc: lowWord = busValue + dataWidth'(1);
            default:  lowWord = '0;
        endcase
    end

    // only multiply fills the high word
    always_comb begin
        if (aluOp == aluMul) begin
            result = product;
        end else begin
            result = {{dataWidth{1'b0}}, lowWord};
        end
    end

endmodule

// File: design/controlSequencer.sv
`timescale 1ns/1ps

module controlSequencer import srcPkg::*; (
    input  logic clock,
    input  logic reset,
    input  logic run,
    output logic memRead,
    output logic halted,
    datapathCtrlIf.sequencer ctrl
);

    stepT step, nextStep;
    logic isTwoOperand;

    function automatic aluOpT aluOpFor(opcodeT op);
        case (op)
            opSub:   return aluSub;
            opAnd:   return aluAnd;
            opOr:    return aluOr;
            opMul:   return aluMul;
            default: return aluAdd;           // add and addi.
        endcase
    endfunction

    assign isTwoOperand = ctrl.irOpcode inside {opAdd, opSub, opAnd, opOr, opAddi, opMul};

    always_ff @(posedge clock) begin
        if (reset) begin
            step <= stIdle;
        end else begin
            step <= nextStep;
        end
    end

    always_comb begin
        nextStep = step;
        case (step)
            stIdle:   nextStep = run ? stT0 : stIdle;
            stT0:     nextStep = stT1;
            stT1:     nextStep = stWait1;
            stWait1:  nextStep = stWait2;
            stWait2:  nextStep = stT2;
            stT2:     nextStep = stT3;
            stT3: begin
                if (isTwoOperand) begin
                    nextStep = stT4;
                end else if (ctrl.irOpcode == opHalt) begin
                    nextStep = stHalted;
                end else begin
                    nextStep = stT0;          // single-step ops and nop.
                end
            end
            stT4:     nextStep = stT5;
            stT5:     nextStep = (ctrl.irOpcode == opMul) ? stT6 : stT0;
            stT6:     nextStep = stT0;
            stHalted: nextStep = stHalted;
            default:  nextStep = stIdle;
        endcase
    end

    assign memRead = (step == stT1);
    assign halted = (step == stHalted);

    // strobe decode
    always_comb begin
        ctrl.pcOut = 1'b0;
        ctrl.mdrOut = 1'b0;
        ctrl.zLowOut = 1'b0;
        ctrl.zHighOut = 1'b0;
        ctrl.hiOut = 1'b0;
        ctrl.loOut = 1'b0;
        ctrl.regOut = 1'b0;
        ctrl.constOut = 1'b0;
        ctrl.inPortOut = 1'b0;
        ctrl.pcIn = 1'b0;
        ctrl.irIn = 1'b0;
        ctrl.marIn = 1'b0;
        ctrl.mdrIn = 1'b0;
        ctrl.yIn = 1'b0;
        ctrl.zIn = 1'b0;
        ctrl.hiIn = 1'b0;
        ctrl.loIn = 1'b0;
        ctrl.regIn = 1'b0;
        ctrl.outPortIn = 1'b0;
        ctrl.gra = 1'b0;
        ctrl.grb = 1'b0;
        ctrl.grc = 1'b0;
        ctrl.aluOp = aluAdd;
        case (step)
            stT0: begin
                ctrl.pcOut = 1'b1;            // pc to mar, pc + 1 into z.
                ctrl.marIn = 1'b1;
                ctrl.aluOp = aluIncPc;
                ctrl.zIn = 1'b1;
            end
            stT1: begin
                ctrl.zLowOut = 1'b1;
                ctrl.pcIn = 1'b1;
            end
            stWait2: ctrl.mdrIn = 1'b1;       // memory data valid here.
            stT2: begin
                ctrl.mdrOut = 1'b1;
                ctrl.irIn = 1'b1;
            end
            stT3: begin
                case (ctrl.irOpcode)
                    opAdd, opSub, opAnd, opOr, opAddi, opMul: begin
                        ctrl.grb = 1'b1;
                        ctrl.regOut = 1'b1;
                        ctrl.yIn = 1'b1;
                    end
                    opMfhi: begin
                        ctrl.hiOut = 1'b1;
                        ctrl.gra = 1'b1;
                        ctrl.regIn = 1'b1;
                    end
                    opMflo: begin
                        ctrl.loOut = 1'b1;
                        ctrl.gra = 1'b1;
                        ctrl.regIn = 1'b1;
                    end
                    opIn: begin
                        ctrl.inPortOut = 1'b1;
                        ctrl.gra = 1'b1;
                        ctrl.regIn = 1'b1;
                    end
                    opOut: begin
                        ctrl.gra = 1'b1;
                        ctrl.regOut = 1'b1;
                        ctrl.outPortIn = 1'b1;
                    end
                    default: ;                // nop and halt.
                endcase
            end
            stT4: begin
                if (ctrl.irOpcode == opAddi) begin
                    ctrl.constOut = 1'b1;
                end else begin
                    ctrl.grc = 1'b1;
                    ctrl.regOut = 1'b1;
                end
                ctrl.aluOp = aluOpFor(ctrl.irOpcode);
                ctrl.zIn = 1'b1;
            end
            stT5: begin
                ctrl.zLowOut = 1'b1;
                if (ctrl.irOpcode == opMul) begin
                    ctrl.loIn = 1'b1;
                end else begin
                    ctrl.gra = 1'b1;
                    ctrl.regIn = 1'b1;
                end
            end
            stT6: begin
                ctrl.zHighOut = 1'b1;         // upper product word.
                ctrl.hiIn = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

// File: design/datapathCore.sv
`timescale 1ns/1ps

module datapathCore import srcPkg::*; (
    input  logic clock,
    input  logic reset,
    datapathCtrlIf.datapath ctrl,
    input  logic [dataWidth-1:0] memData,
    output logic [memAddrWidth-1:0] memAddress,
    input  logic [dataWidth-1:0] inData,
    output logic [dataWidth-1:0] outData,
    output logic outValid
);

    logic [dataWidth-1:0] pc, ir, mdr, y, hi, lo;
    logic [dataWidth-1:0] inPort, outPort;
    logic [memAddrWidth-1:0] mar;
    logic [2*dataWidth-1:0] z, aluResult;
    logic [dataWidth-1:0] bus, regValue, constValue;

    registerFile registerFile_inst (
        .clock  (clock),
        .reset  (reset),
        .ctrl   (ctrl),
        .irWord (ir),
        .busIn  (bus),
        .busOut (regValue)
    );

    aluUnit aluUnit_inst (
        .aluOp    (ctrl.aluOp),
        .yValue   (y),
        .busValue (bus),
        .result   (aluResult)
    );

    assign constValue = {{(dataWidth-constWidth){ir[constWidth-1]}}, ir[constWidth-1:0]};

    // one driver at a time, idle bus reads zero
    always_comb begin
        if (ctrl.pcOut) begin
            bus = pc;
        end else if (ctrl.mdrOut) begin
            bus = mdr;
        end else if (ctrl.zLowOut) begin
            bus = z[dataWidth-1:0];
        end else if (ctrl.zHighOut) begin
            bus = z[2*dataWidth-1:dataWidth];
        end else if (ctrl.hiOut) begin
            bus = hi;
        end else if (ctrl.loOut) begin
            bus = lo;
        end else if (ctrl.regOut) begin
            bus = regValue;
        end else if (ctrl.constOut) begin
            bus = constValue;
        end else if (ctrl.inPortOut) begin
            bus = inPort;
        end else begin
            bus = '0;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            pc <= '0;
            ir <= '0;
            outValid <= 1'b0;
        end else begin
            if (ctrl.pcIn) pc <= bus;
            if (ctrl.irIn) ir <= bus;
            outValid <= ctrl.outPortIn;   // one cycle after the out step.
        end
    end

    always_ff @(posedge clock) begin
        inPort <= inData;                 // sampled every cycle.
        if (ctrl.marIn) mar <= bus[memAddrWidth-1:0];
        if (ctrl.mdrIn) mdr <= memData;
        if (ctrl.yIn) y <= bus;
        if (ctrl.zIn) z <= aluResult;
        if (ctrl.hiIn) hi <= bus;
        if (ctrl.loIn) lo <= bus;
        if (ctrl.outPortIn) outPort <= bus;
    end

    assign ctrl.irOpcode = opcodeT'(ir[opcodeMsb -: opcodeWidth]);
    assign memAddress = mar;
    assign outData = outPort;

endmodule

// File: design/datapathCtrlIf.sv
`timescale 1ns/1ps

interface datapathCtrlIf import srcPkg::*; ();

    // bus drivers
    logic pcOut, mdrOut, zLowOut, zHighOut, hiOut, loOut;
    logic regOut, constOut, inPortOut;

    // loads from the bus
    logic pcIn, irIn, marIn, mdrIn, yIn, zIn, hiIn, loIn;
    logic regIn, outPortIn;

    logic gra, grb, grc;     // register field select.
    aluOpT aluOp;
    opcodeT irOpcode;        // back to the sequencer.

    modport sequencer (
        output pcOut, mdrOut, zLowOut, zHighOut, hiOut, loOut,
        output regOut, constOut, inPortOut,
        output pcIn, irIn, marIn, mdrIn, yIn, zIn, hiIn, loIn,
        output regIn, outPortIn,
        output gra, grb, grc, aluOp,
        input  irOpcode
    );

    modport datapath (
        input  pcOut, mdrOut, zLowOut, zHighOut, hiOut, loOut,
        input  regOut, constOut, inPortOut,
        input  pcIn, irIn, marIn, mdrIn, yIn, zIn, hiIn, loIn,
        input  regIn, outPortIn,
        input  gra, grb, grc, aluOp,
        output irOpcode
    );

endinterface

// File: design/miniCpuTop.sv
`timescale 1ns/1ps

module miniCpuTop import srcPkg::*; (
    input  logic clock,
    input  logic reset,
    input  logic run,
    input  logic loadEnable,
    input  logic [memAddrWidth-1:0] loadAddress,
    input  logic [dataWidth-1:0] loadData,
    input  logic [dataWidth-1:0] inData,
    output logic [dataWidth-1:0] outData,
    output logic outValid,
    output logic halted
);

    datapathCtrlIf ctrlBus ();

    logic memRead;
    logic [dataWidth-1:0] memData;
    logic [memAddrWidth-1:0] memAddress;

    controlSequencer controlSequencer_inst (
        .clock   (clock),
        .reset   (reset),
        .run     (run),
        .memRead (memRead),
        .halted  (halted),
        .ctrl    (ctrlBus.sequencer)
    );

    datapathCore datapathCore_inst (
        .clock      (clock),
        .reset      (reset),
        .ctrl       (ctrlBus.datapath),
        .memData    (memData),
        .memAddress (memAddress),
        .inData     (inData),
        .outData    (outData),
        .outValid   (outValid)
    );

    programMemory programMemory_inst (
        .clock       (clock),
        .loadEnable  (loadEnable),
        .loadAddress (loadAddress),
        .loadData    (loadData),
        .memRead     (memRead),
        .memAddress  (memAddress),
        .memData     (memData)
    );

endmodule

// File: design/programMemory.sv
`timescale 1ns/1ps

module programMemory import srcPkg::*; (
    input  logic clock,
    input  logic loadEnable,
    input  logic [memAddrWidth-1:0] loadAddress,
    input  logic [dataWidth-1:0] loadData,
    input  logic memRead,
    input  logic [memAddrWidth-1:0] memAddress,
    output logic [dataWidth-1:0] memData
);

    logic [dataWidth-1:0] mem [memDepth];
    logic [memLatency-2:0] readPipe;                      // pending read per stage.
    logic [memAddrWidth-1:0] addrPipe [memLatency-1];

    always_ff @(posedge clock) begin
        if (loadEnable) mem[loadAddress] <= loadData;
    end

    // address travels with its strobe so reads can overlap
    always_ff @(posedge clock) begin
        readPipe[0] <= memRead;
        addrPipe[0] <= memAddress;
        for (int i = 1; i < memLatency - 1; i++) begin
            readPipe[i] <= readPipe[i-1];
            addrPipe[i] <= addrPipe[i-1];
        end
        if (readPipe[memLatency-2]) begin
            memData <= mem[addrPipe[memLatency-2]];       // held until next read.
        end
    end

endmodule

// File: design/registerFile.sv
`timescale 1ns/1ps

module registerFile import srcPkg::*; (
    input  logic clock,
    input  logic reset,
    datapathCtrlIf.datapath ctrl,
    input  logic [dataWidth-1:0] irWord,
    input  logic [dataWidth-1:0] busIn,
    output logic [dataWidth-1:0] busOut
);

    logic [dataWidth-1:0] regs [regCount];
    logic [regIdxWidth-1:0] regSel;

    always_comb begin
        if (ctrl.gra) begin
            regSel = irWord[raMsb -: regIdxWidth];
        end else if (ctrl.grb) begin
            regSel = irWord[rbMsb -: regIdxWidth];
        end else if (ctrl.grc) begin
            regSel = irWord[rcMsb -: regIdxWidth];
        end else begin
            regSel = '0;
        end
    end

    assign busOut = (regSel == '0) ? '0 : regs[regSel];   // r0 is hardwired zero.

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < regCount; i++) begin
                regs[i] <= '0;
            end
        end else if (ctrl.regIn && regSel != '0) begin
            regs[regSel] <= busIn;
        end
    end

endmodule

// File: design/srcPkg.sv
package srcPkg;

    localparam int dataWidth = 32;                  // bus and register width.
    localparam int regCount = 16;
    localparam int regIdxWidth = $clog2(regCount);
    localparam int memDepth = 256;
    localparam int memAddrWidth = $clog2(memDepth);
    localparam int memLatency = 2;                  // read strobe to valid data.

    // instruction field layout
    localparam int opcodeWidth = 5;
    localparam int opcodeMsb = 31;
    localparam int raMsb = 26;
    localparam int rbMsb = 22;
    localparam int rcMsb = 18;
    localparam int constWidth = 19;                 // sign-extended immediate.

    typedef enum logic [opcodeWidth-1:0] {
        opAdd  = 5'b00011,
        opSub  = 5'b00100,
        opAnd  = 5'b01001,
        opOr   = 5'b01010,
        opAddi = 5'b01011,
        opMul  = 5'b01110,
        opIn   = 5'b10101,
        opOut  = 5'b10110,
        opMfhi = 5'b10111,
        opMflo = 5'b11000,
        opNop  = 5'b11010,
        opHalt = 5'b11011
    } opcodeT;

    typedef enum logic [2:0] {
        aluAdd, aluSub, aluAnd, aluOr, aluMul, aluIncPc
    } aluOpT;

    typedef enum logic [3:0] {
        stIdle, stT0, stT1, stWait1, stWait2,
        stT2, stT3, stT4, stT5, stT6, stHalted
    } stepT;

endpackage

// File: filelist.f
design/srcPkg.sv
design/datapathCtrlIf.sv
design/registerFile.sv
design/aluUnit.sv
design/datapathCore.sv
design/controlSequencer.sv
design/programMemory.sv
design/miniCpuTop.sv
tb/cpuChecks_asserts.sv
tb/cpuTb.sv

// File: runSim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module cpuTb \
    -f filelist.f -o cpuSim > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "build failed"
    exit 1
fi

./obj_dir/cpuSim +verilator+error+limit+100 > sim.log 2>&1
simStatus=$?
cat sim.log

if grep -q "Done: errors found" sim.log; then
    echo "FAIL"
    exit 1
fi
if [ $simStatus -ne 0 ]; then
    echo "simulation exited with status $simStatus"
    exit 1
fi
echo "PASS"
exit 0

// File: tb/cpuChecks_asserts.sv
`timescale 1ns/1ps

module cpuChecks_asserts (
    input logic clock,
    input logic reset,
    input logic memRead,
    input logic halted,
    datapathCtrlIf.sequencer ctrl
);

    int unsigned failures = 0;
    logic [8:0] drivers;

    assign drivers = {ctrl.pcOut, ctrl.mdrOut, ctrl.zLowOut, ctrl.zHighOut, ctrl.hiOut,
                      ctrl.loOut, ctrl.regOut, ctrl.constOut, ctrl.inPortOut};

    resetClearsRead: assert property (@(posedge clock) reset |=> !memRead)
        else begin
            $error("memRead high in the cycle after reset");
            failures++;
        end

    singleDriver: assert property (@(posedge clock) disable iff (reset) $onehot0(drivers))
        else begin
            $error("more than one bus driver strobe high");
            failures++;
        end

    haltSticks: assert property (@(posedge clock) disable iff (reset) halted |=> halted)
        else begin
            $error("halted fell without reset");
            failures++;
        end

    // one read per fetch, never back to back
    noDoubleRead: assert property (@(posedge clock) disable iff (reset) memRead |=> !memRead)
        else begin
            $error("memRead high in two consecutive steps");
            failures++;
        end

endmodule

bind controlSequencer cpuChecks_asserts sequencerChecks (
    .clock   (clock),
    .reset   (reset),
    .memRead (memRead),
    .halted  (halted),
    .ctrl    (ctrl)
);

// File: tb/cpuStimulus.txt
# P address word : program load, I value : input port, E value : next out value
# X value : value of the final out, still on the port after halt
I 1234ABCD
P 00 A8800000
P 01 B0800000
P 02 59012345
P 03 5996E444
P 04 1A118000
P 05 22990000
P 06 4B118000
P 07 53918000
P 08 B2000000
P 09 B2800000
P 0A B3000000
P 0B B3800000
P 0C 58000055
P 0D 70298000
P 0E BC000000
P 0F C4800000
P 10 B4000000
P 11 B4800000
P 12 5D000777
P 13 B5000000
P 14 D0000000
P 15 D8000000
E 1234ABCD
E 00012ACE
E FFFEE444
E 00000301
E 000127CD
E FFFFFFFF
E F7A60464
X 00000777

// File: tb/cpuTb.sv
`timescale 1ns/1ps

module cpuTb import srcPkg::*; ();

    logic clock;
    logic reset;
    logic run;
    logic loadEnable;
    logic [memAddrWidth-1:0] loadAddress;
    logic [dataWidth-1:0] loadData;
    logic [dataWidth-1:0] inData;
    logic [dataWidth-1:0] outData;
    logic outValid;
    logic halted;

    logic [memAddrWidth-1:0] progAddr [$];
    logic [dataWidth-1:0] progWord [$];
    logic [dataWidth-1:0] expected [$];          // out values, in program order.
    logic [dataWidth-1:0] inValue;
    logic [dataWidth-1:0] finalValue;
    logic stimulusRead = 1'b0;

    miniCpuTop miniCpuTop_inst (
        .clock       (clock),
        .reset       (reset),
        .run         (run),
        .loadEnable  (loadEnable),
        .loadAddress (loadAddress),
        .loadData    (loadData),
        .inData      (inData),
        .outData     (outData),
        .outValid    (outValid),
        .halted      (halted)
    );

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;              // 100 ns period.
    end

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("Done: errors found");
        $fatal(1, "run aborted");
    endtask

    task automatic checkValue(input string name, input logic [dataWidth-1:0] actual,
                              input logic [dataWidth-1:0] wanted);
        if (actual !== wanted) begin
            abortRun($sformatf("ERR %s: got %h, expected %h", name, actual, wanted));
        end
    endtask

    task automatic readStimulus();
        int fd;
        int code;
        logic [7:0] tag;
        logic [8*160-1:0] rest;
        logic [31:0] addr;
        logic [31:0] word;
        fd = $fopen("tb/cpuStimulus.txt", "r");
        if (fd == 0) begin
            abortRun("could not open the stimulus file tb/cpuStimulus.txt");
        end else begin
            while (!$feof(fd)) begin
                code = $fscanf(fd, "%s", tag);
                if (code == 1) begin
                    case (tag)
                        "P": begin
                            code = $fscanf(fd, "%h %h", addr, word);
                            progAddr.push_back(addr[memAddrWidth-1:0]);
                            progWord.push_back(word);
                        end
                        "I": code = $fscanf(fd, "%h", inValue);
                        "E": begin
                            code = $fscanf(fd, "%h", word);
                            expected.push_back(word);
                        end
                        "X": begin
                            code = $fscanf(fd, "%h", finalValue);
                            expected.push_back(finalValue);   // last out of the run.
                        end
                        default: code = $fgets(rest, fd);     // comment line.
                    endcase
                end
            end
            $fclose(fd);
        end
    endtask

    initial begin
        reset = 1'b1;
        run = 1'b0;
        loadEnable = 1'b0;
        loadAddress = '0;
        loadData = '0;
        inData = '0;
        readStimulus();
        stimulusRead = 1'b1;
        repeat (2) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        checkValue("halted", halted, '0);
        checkValue("outValid", outValid, '0);
        foreach (progWord[i]) begin
            loadEnable = 1'b1;
            loadAddress = progAddr[i];
            loadData = progWord[i];
            @(negedge clock);
        end
        loadEnable = 1'b0;
        inData = inValue;
        run = 1'b1;
        while (!halted) @(negedge clock);
        checkValue("outData", outData, finalValue);   // port holds the last value.
        repeat (4) @(negedge clock);                  // watch for late pulses.
        @(posedge clock);
        if (expected.size() != 0) begin
            abortRun($sformatf("%0d expected output values were never produced",
                               expected.size()));
        end else begin
            $display("Done: no errors");
            $finish;
        end
    end

    // output pulses and sequencer assertions.
    always @(negedge clock) begin
        if (miniCpuTop_inst.controlSequencer_inst.sequencerChecks.failures != 0) begin
            abortRun("a sequencer assertion failed, see the messages above");
        end else if (!reset && outValid) begin
            if (halted) begin
                abortRun("an output pulse came after the CPU halted");
            end else if (expected.size() == 0) begin
                abortRun("an output pulse came with no expected value left");
            end else begin
                checkValue("outData", outData, expected.pop_front());
            end
        end
    end

    initial begin
        wait (stimulusRead);
        #((progWord.size() * 12 + 50) * 100);
        abortRun($sformatf("timeout: the CPU did not halt within %0d cycles",
                           progWord.size() * 12 + 50));
    end

endmodule
